//--- irq_sleep.f
+incdir+src
src/irq_pkg.sv
src/irq_capture.sv
src/irq_arbiter.sv
src/wfi_sleep_ctrl.sv
src/irq_sleep_top.sv
sim/irq_sleep_assert.sv
sim/tb_clkgen.sv
sim/tb_irq_sleep.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_irq_sleep -f irq_sleep.f \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_irq_sleep +verilator+error+limit+1000 > "$LOG" 2>&1 \
  || echo "Simulator exited with an error status" >> "$LOG"
cat "$LOG"

grep -q "Simulation failed" "$LOG" && { echo "Result: FAIL"; exit 1; }
grep -q "Simulation passed" "$LOG" || { echo "Result: FAIL, no verdict in log"; exit 1; }
echo "Result: PASS"

//--- sim/irq_sleep_assert.sv
// Concurrent checks on the ports of the interrupt and sleep unit.
// Bound into irq_sleep_top by the testbench.

`include "irq_defines.svh"

module irq_sleep_assert (
  input logic              clk_i,
  input logic              rst_ni,
  input irq_pkg::irq_vec_t irq_i,
  input irq_pkg::irq_vec_t mie_i,
  input logic              mstatus_mie_i,
  input logic              irq_ready_i,
  input logic              wfi_valid_i,
  input logic              bus_busy_i,
  input logic              debug_req_i,
  input irq_pkg::irq_vec_t mip_o,
  input logic              irq_valid_o,
  input irq_pkg::irq_id_t  irq_id_o,
  input logic              irq_ack_o,
  input logic              wfi_ready_o,
  input logic              core_sleep_o
);

  // Number of failed checks so far
  int unsigned fail_cnt = 0;

  irq_pkg::irq_vec_t irq_q;
  irq_pkg::irq_vec_t en_pend_q;
  irq_pkg::irq_id_t  id_q;
  logic              mstatus_q;
  logic              valid_q;
  logic              ready_q;
  logic              ack_q;
  logic              no_sleep_q;
  logic              in_reset_q = 1'b0;
  logic [2:0]        wfi_age;
  logic [2:0]        quiet_run;
  logic              wake;
  logic              quiet;
  logic [`IRQ_ID_W:0] exp_win;

  // Winner in the order 31 down to 16, then 11, 3, 7
  // Top bit flags that any line was set
  function automatic logic [`IRQ_ID_W:0] top_line(irq_pkg::irq_vec_t v);
    logic [`IRQ_ID_W:0] res;
    res = '0;
    for (int i = `IRQ_NUM - 1; i >= 16; i--) begin
      if (!res[`IRQ_ID_W] && v[i]) begin
        res = {1'b1, irq_pkg::irq_id_t'(i)};
      end
    end
    if (!res[`IRQ_ID_W] && v[11]) res = {1'b1, irq_pkg::irq_id_t'(11)};
    if (!res[`IRQ_ID_W] && v[3])  res = {1'b1, irq_pkg::irq_id_t'(3)};
    if (!res[`IRQ_ID_W] && v[7])  res = {1'b1, irq_pkg::irq_id_t'(7)};
    return res;
  endfunction

  assign wake    = |(mip_o & mie_i);
  assign quiet   = !bus_busy_i && !debug_req_i && !wake;
  assign exp_win = top_line(en_pend_q);

  // ------------------------------------------------------------------
  // History of the previous cycle
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q      <= '0;
      en_pend_q  <= '0;
      id_q       <= '0;
      mstatus_q  <= 1'b0;
      valid_q    <= 1'b0;
      ready_q    <= 1'b0;
      ack_q      <= 1'b0;
      no_sleep_q <= 1'b1;
      wfi_age    <= '0;
      quiet_run  <= '0;
    end else begin
      irq_q      <= irq_i;
      en_pend_q  <= mip_o & mie_i;
      id_q       <= irq_id_o;
      mstatus_q  <= mstatus_mie_i;
      valid_q    <= irq_valid_o;
      ready_q    <= irq_ready_i;
      ack_q      <= irq_ack_o;
      no_sleep_q <= !wfi_valid_i || !quiet;
      // Consecutive WFI cycles, and those of them with nothing blocking sleep
      wfi_age    <= !wfi_valid_i ? 3'd0 : (wfi_age == 3'd7 ? wfi_age : wfi_age + 3'd1);
      quiet_run  <= !(wfi_valid_i && quiet) ? 3'd0 :
                    (quiet_run == 3'd7 ? quiet_run : quiet_run + 3'd1);
    end
  end

  always_ff @(posedge clk_i) begin
    in_reset_q <= !rst_ni;
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  a_reset: assert property (@(posedge clk_i) (!rst_ni && in_reset_q) |->
    (mip_o == '0) && !irq_valid_o && !irq_ack_o && !wfi_ready_o && !core_sleep_o)
    else begin
      fail_cnt++;
      $error("Outputs were not all low during reset");
    end

  a_mip: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mip_o == (irq_q & `IRQ_VALID_MASK))
    else begin
      fail_cnt++;
      $error("ERROR mip_o %h expected %h", mip_o, irq_q & `IRQ_VALID_MASK);
    end

  a_mip_reserved: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mip_o & ~`IRQ_VALID_MASK) == '0)
    else begin
      fail_cnt++;
      $error("ERROR mip_o %h has reserved bits set", mip_o);
    end

  a_priority: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_valid_o && !valid_q) |->
      mstatus_q && exp_win[`IRQ_ID_W] && (irq_id_o == exp_win[`IRQ_ID_W-1:0]))
    else begin
      fail_cnt++;
      $error("ERROR irq_id_o %h expected %h", irq_id_o, exp_win[`IRQ_ID_W-1:0]);
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_q && !ready_q) |-> irq_valid_o && (irq_id_o == id_q))
    else begin
      fail_cnt++;
      $error("ERROR irq_id_o %h expected %h", irq_id_o, id_q);
    end

  a_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_q && ready_q) |-> !irq_valid_o)
    else begin
      fail_cnt++;
      $error("Request stayed valid right after it was accepted");
    end

  a_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_ack_o == (irq_valid_o && irq_ready_i)) && !(irq_ack_o && ack_q))
    else begin
      fail_cnt++;
      $error("ERROR irq_ack_o %h expected %h", irq_ack_o,
        irq_valid_o && irq_ready_i && !ack_q);
    end

  a_sleep_early: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wfi_valid_i && (wfi_age < `WFI_SLEEP_DELAY)) |-> !core_sleep_o)
    else begin
      fail_cnt++;
      $error("ERROR core_sleep_o %h expected 0 during dwell", core_sleep_o);
    end

  a_sleep_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((wfi_age == `WFI_SLEEP_DELAY) && (quiet_run >= `WFI_SLEEP_DELAY)) |-> core_sleep_o)
    else begin
      fail_cnt++;
      $error("ERROR core_sleep_o %h expected 1 after dwell", core_sleep_o);
    end

  a_sleep_block: assert property (@(posedge clk_i) disable iff (!rst_ni)
    no_sleep_q |-> !core_sleep_o)
    else begin
      fail_cnt++;
      $error("ERROR core_sleep_o %h expected 0 when held awake", core_sleep_o);
    end

  a_wfi_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wfi_ready_o == (wfi_valid_i && wake))
    else begin
      fail_cnt++;
      $error("ERROR wfi_ready_o %h expected %h", wfi_ready_o, wfi_valid_i && wake);
    end

endmodule

//--- sim/tb_clkgen.sv
// Clock and reset source for the testbench.
// Free-running clock with a period of 10, reset held low for two cycles.

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release just after the second rising edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- sim/tb_irq_sleep.sv
// Testbench for the interrupt and sleep unit.
// Walks the DUT through pending, priority, handshake, sleep and wake tests
// while the bound checker does the checking. Prints one line per test.

`include "irq_defines.svh"

module tb_irq_sleep;

  localparam int        NUM_TESTS  = 5;
  localparam int        CLK_PERIOD = 10;
  localparam bit [31:0] SEED       = 32'hf59e14fd;
  localparam int        WAIT_VALID = 0;
  localparam int        WAIT_SLEEP = 1;
  localparam int        WAIT_RETIRE = 2;

  logic              clk;
  logic              rst_n;
  irq_pkg::irq_vec_t irq;
  irq_pkg::irq_vec_t mie;
  logic              mstatus_mie;
  logic              irq_ready;
  logic              wfi_valid;
  logic              bus_busy;
  logic              debug_req;
  irq_pkg::irq_vec_t mip;
  logic              irq_valid;
  irq_pkg::irq_id_t  irq_id;
  logic              irq_ack;
  logic              wfi_ready;
  logic              core_sleep;
  int                tb_errs = 0;
  int                tests_failed = 0;
  int                start_errs;

  tb_clkgen tb_clkgen_i (.clk_o(clk), .rst_no(rst_n));

  irq_sleep_top irq_sleep_top_i (
    .clk_i (clk), .rst_ni (rst_n), .irq_i (irq), .mie_i (mie),
    .mstatus_mie_i (mstatus_mie), .irq_ready_i (irq_ready), .mip_o (mip),
    .irq_valid_o (irq_valid), .irq_id_o (irq_id), .irq_ack_o (irq_ack),
    .wfi_valid_i (wfi_valid), .bus_busy_i (bus_busy), .debug_req_i (debug_req),
    .wfi_ready_o (wfi_ready), .core_sleep_o (core_sleep)
  );

  bind irq_sleep_top irq_sleep_assert irq_sleep_assert_i (
    .clk_i (clk_i), .rst_ni (rst_ni), .irq_i (irq_i), .mie_i (mie_i),
    .mstatus_mie_i (mstatus_mie_i), .irq_ready_i (irq_ready_i),
    .wfi_valid_i (wfi_valid_i), .bus_busy_i (bus_busy_i), .debug_req_i (debug_req_i),
    .mip_o (mip_o), .irq_valid_o (irq_valid_o), .irq_id_o (irq_id_o),
    .irq_ack_o (irq_ack_o), .wfi_ready_o (wfi_ready_o), .core_sleep_o (core_sleep_o)
  );

  function automatic int error_total();
    return tb_errs + int'(irq_sleep_top_i.irq_sleep_assert_i.fail_cnt);
  endfunction

  // Inputs change 1 unit after the rising edge
  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_until(input int sel, input string what, input int max_cycles);
    int  n;
    bit  hit;
    n   = 0;
    hit = 1'b0;
    while (!hit && n < max_cycles) begin
      step(1);
      n++;
      case (sel)
        WAIT_VALID: hit = irq_valid;
        WAIT_SLEEP: hit = core_sleep;
        default:    hit = wfi_ready;
      endcase
    end
    if (!hit) begin
      tb_errs++;
      $display("Timed out after %0d cycles waiting for %s", max_cycles, what);
    end
  endtask

  task automatic finish_test(input int idx, input string name);
    int new_errs;
    new_errs = error_total() - start_errs;
    if (new_errs == 0) begin
      $display("test %0d %s: ok", idx, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", idx, name, new_errs);
    end
    start_errs = error_total();
  endtask

  // Random implemented line out of 16..31, 3, 7 and 11
  function automatic int pick_line();
    int idx;
    idx = int'($urandom % 19);
    if (idx < 16) return 16 + idx;
    return (idx == 16) ? 3 : ((idx == 17) ? 7 : 11);
  endfunction

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------

  task automatic priority_rounds();
    for (int k = 0; k < 16; k++) begin
      irq = $urandom;
      if ($urandom % 2 == 1) irq = irq & 32'h0000_0888;
      if ((irq & `IRQ_VALID_MASK) == '0) irq = irq | (32'd1 << pick_line());
      mie = $urandom;
      if ((irq & mie & `IRQ_VALID_MASK) == '0) mie = mie | irq;
      mstatus_mie = 1'b1;
      wait_until(WAIT_VALID, "irq_valid_o", 8);
      irq         = '0;
      mstatus_mie = 1'b0;
      step(int'($urandom % 4));
      irq_ready = 1'b1;
      step(1);
      irq_ready = 1'b0;
      step(2);
    end
  endtask

  task automatic handshake_stress();
    mie         = `IRQ_VALID_MASK;
    mstatus_mie = 1'b1;
    for (int c = 0; c < 60; c++) begin
      if (c % 6 == 0) irq = $urandom | 32'h0001_0000;
      irq_ready = ($urandom % 4 == 0);
      step(1);
    end
    irq         = '0;
    mstatus_mie = 1'b0;
    irq_ready   = 1'b1;
    step(3);
    irq_ready = 1'b0;
    mie       = '0;
    step(1);
  endtask

  task automatic sleep_entry_runs();
    wfi_valid = 1'b1;
    wait_until(WAIT_SLEEP, "core_sleep_o to rise", 6);
    bus_busy = 1'b1;
    step(3 + int'($urandom % 4));
    bus_busy = 1'b0;
    wait_until(WAIT_SLEEP, "core_sleep_o after bus activity", 6);
    wfi_valid = 1'b0;
    step(2);
    // WFI arriving while the bus is still busy
    bus_busy  = 1'b1;
    wfi_valid = 1'b1;
    step(5);
    bus_busy = 1'b0;
    wait_until(WAIT_SLEEP, "core_sleep_o once the bus went idle", 6);
    wfi_valid = 1'b0;
    step(2);
  endtask

  task automatic wake_and_retire();
    int line;
    line      = pick_line();
    wfi_valid = 1'b1;
    wait_until(WAIT_SLEEP, "core_sleep_o to rise", 6);
    debug_req = 1'b1;
    step(2);
    debug_req = 1'b0;
    wait_until(WAIT_SLEEP, "core_sleep_o after the debug request", 6);
    // An enabled line wakes the core even with the global enable off
    mie = 32'd1 << line;
    step(1);
    irq = 32'd1 << line;
    wait_until(WAIT_RETIRE, "wfi_ready_o", 4);
    step(1);
    wfi_valid = 1'b0;
    irq       = '0;
    mie       = '0;
    step(3);
  endtask

  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    irq = '0;
    mie = '0;
    mstatus_mie = 1'b0;
    irq_ready = 1'b0;
    wfi_valid = 1'b0;
    bus_busy = 1'b0;
    debug_req = 1'b0;
    void'($urandom(SEED));
    @(posedge rst_n);
    step(2);
    start_errs = error_total();
    for (int c = 0; c < 30; c++) begin
      irq = $urandom;
      step(1);
    end
    irq = '0;
    step(2);
    finish_test(1, "pending register");
    priority_rounds();
    finish_test(2, "priority");
    handshake_stress();
    finish_test(3, "handshake");
    sleep_entry_runs();
    finish_test(4, "sleep entry");
    wake_and_retire();
    finish_test(5, "wake and retire");
    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, error_total());
    if (error_total() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- src/irq_arbiter.sv
// Fixed-priority interrupt arbiter with a valid/ready request to the core.
// The winner is held until accepted; acceptance produces a one-cycle ack.
// Also flags any enabled pending line as a wake reason for the WFI logic.

`include "irq_defines.svh"

module irq_arbiter (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Pending and enable state
  input  irq_pkg::irq_vec_t pending_i,
  input  irq_pkg::irq_vec_t mie_i,
  input  logic              mstatus_mie_i,

  // Request to the core
  input  logic              irq_ready_i,
  output logic              irq_valid_o,
  output irq_pkg::irq_id_t  irq_id_o,
  output logic              irq_ack_o,

  // Wake reason for the sleep controller
  output logic              wake_o
);

  irq_pkg::irq_vec_t enabled_pend;
  logic              sel_valid;
  irq_pkg::irq_id_t  sel_id;
  logic              load_req;
  logic              req_valid_q;
  irq_pkg::irq_id_t  req_id_q;

  // ------------------------------------------------------------------
  // Enabled pending lines
  // ------------------------------------------------------------------

  assign enabled_pend = pending_i & mie_i;

  // Wake ignores the global enable, a masked interrupt still ends WFI
  assign wake_o    = |enabled_pend;
  assign sel_valid = wake_o;

  // ------------------------------------------------------------------
  // Priority select
  // ------------------------------------------------------------------

  // Checked lowest priority first so later hits override earlier ones.
  // Resulting order is 31..16, 11, 3, 7
  always_comb begin
    sel_id = '0;
    if (enabled_pend[7]) begin
      sel_id = irq_pkg::irq_id_t'(7);
    end
    if (enabled_pend[3]) begin
      sel_id = irq_pkg::irq_id_t'(3);
    end
    if (enabled_pend[11]) begin
      sel_id = irq_pkg::irq_id_t'(11);
    end
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (enabled_pend[i]) begin
        sel_id = irq_pkg::irq_id_t'(i);
      end
    end
  end

  // ------------------------------------------------------------------
  // Request register
  // ------------------------------------------------------------------

  // New winner only when nothing is held, so valid drops for a cycle
  // after every acceptance
  assign load_req = !req_valid_q && mstatus_mie_i && sel_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (load_req) begin
      req_valid_q <= 1'b1;
    end else if (req_valid_q && irq_ready_i) begin
      req_valid_q <= 1'b0;
    end
  end

  // Identifier stays frozen while the request waits for ready
  always_ff @(posedge clk_i) begin
    if (load_req) begin
      req_id_q <= sel_id;
    end
  end

  assign irq_valid_o = req_valid_q;
  assign irq_id_o    = req_id_q;

  // Accepted in the cycle where valid meets ready
  assign irq_ack_o   = req_valid_q & irq_ready_i;

endmodule

//--- src/irq_capture.sv
// Interrupt pending register.
// Samples the external lines once per cycle and clears the reserved bits,
// giving the architectural mip value that also feeds the arbiter.

`include "irq_defines.svh"

module irq_capture (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Raw external interrupt lines
  input  irq_pkg::irq_vec_t irq_i,

  // Masked, registered pending vector
  output irq_pkg::irq_vec_t mip_o
);

  // ------------------------------------------------------------------
  // Masking
  // ------------------------------------------------------------------

  irq_pkg::irq_vec_t irq_masked;
  irq_pkg::irq_vec_t mip_q;

  // Lines outside the implemented set never become pending
  assign irq_masked = irq_i & `IRQ_VALID_MASK;

  // ------------------------------------------------------------------
  // Pending register
  // ------------------------------------------------------------------

  // One cycle from irq_i to mip_o
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_masked;
    end
  end

  assign mip_o = mip_q;

endmodule

//--- src/irq_defines.svh
// Shared sizes and constants for the interrupt and sleep unit.
// Include in any file that needs line counts, widths or timing constants.

`ifndef IRQ_DEFINES_SVH
`define IRQ_DEFINES_SVH

// Number of external interrupt lines
`define IRQ_NUM 32

// Width of an interrupt identifier
`define IRQ_ID_W 5

// Implemented lines: 31..16 (platform), 11 (external), 7 (timer), 3 (software)
`define IRQ_VALID_MASK 32'hFFFF_0888

// Cycles a WFI must sit in writeback before the core may sleep
`define WFI_SLEEP_DELAY 2

`endif

//--- src/irq_pkg.sv
// Types shared by the interrupt and sleep unit.
// Referenced by scoped name from the RTL and the bound checker.

`include "irq_defines.svh"

package irq_pkg;

  // ------------------------------------------------------------------
  // Interrupt vectors and identifiers
  // ------------------------------------------------------------------

  // One bit per external interrupt line
  typedef logic [`IRQ_NUM-1:0] irq_vec_t;

  // Index of a single interrupt line
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;

  // ------------------------------------------------------------------
  // Sleep controller
  // ------------------------------------------------------------------

  typedef enum logic [1:0] {
    IDLE   = 2'd0,  // No WFI in writeback
    DWELL  = 2'd1,  // WFI waiting for the dwell time or an idle bus
    ASLEEP = 2'd2   // Core clock may be gated
  } sleep_state_e;

endpackage

//--- src/irq_sleep_top.sv
// Machine-mode interrupt and sleep unit.
// Registers the interrupt lines, raises a held request to the core and
// handles WFI sleep and wake-up.

`include "irq_defines.svh"

module irq_sleep_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // External interrupt lines and CSR enables
  input  irq_pkg::irq_vec_t irq_i,
  input  irq_pkg::irq_vec_t mie_i,
  input  logic              mstatus_mie_i,

  // Interrupt request to the core
  input  logic              irq_ready_i,
  output irq_pkg::irq_vec_t mip_o,
  output logic              irq_valid_o,
  output irq_pkg::irq_id_t  irq_id_o,
  output logic              irq_ack_o,

  // WFI and sleep
  input  logic              wfi_valid_i,
  input  logic              bus_busy_i,
  input  logic              debug_req_i,
  output logic              wfi_ready_o,
  output logic              core_sleep_o
);

  irq_pkg::irq_vec_t pending_vec;
  logic              wake_pend;

  // ------------------------------------------------------------------
  // Pending register
  // ------------------------------------------------------------------

  irq_capture irq_capture_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .irq_i  (irq_i),
    .mip_o  (pending_vec)
  );

  assign mip_o = pending_vec;

  // ------------------------------------------------------------------
  // Arbitration and request
  // ------------------------------------------------------------------

  irq_arbiter irq_arbiter_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pending_i     (pending_vec),
    .mie_i         (mie_i),
    .mstatus_mie_i (mstatus_mie_i),
    .irq_ready_i   (irq_ready_i),
    .irq_valid_o   (irq_valid_o),
    .irq_id_o      (irq_id_o),
    .irq_ack_o     (irq_ack_o),
    .wake_o        (wake_pend)
  );

  // ------------------------------------------------------------------
  // WFI sleep
  // ------------------------------------------------------------------

  wfi_sleep_ctrl wfi_sleep_ctrl_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wfi_valid_i  (wfi_valid_i),
    .wfi_ready_o  (wfi_ready_o),
    .wake_i       (wake_pend),
    .debug_req_i  (debug_req_i),
    .bus_busy_i   (bus_busy_i),
    .core_sleep_o (core_sleep_o)
  );

endmodule

//--- src/wfi_sleep_ctrl.sv
// WFI sleep controller.
// Counts the writeback dwell of a WFI, raises core_sleep_o once the bus is
// idle and nothing wants the core awake, and retires the WFI on a wake.

`include "irq_defines.svh"

module wfi_sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,

  // WFI in writeback, retired with wfi_ready_o
  input  logic wfi_valid_i,
  output logic wfi_ready_o,

  // Wake and hold-off reasons
  input  logic wake_i,
  input  logic debug_req_i,
  input  logic bus_busy_i,

  // Clock gating request
  output logic core_sleep_o
);

  localparam int CNT_W = $clog2(`WFI_SLEEP_DELAY + 1);

  irq_pkg::sleep_state_e state_q;
  irq_pkg::sleep_state_e state_d;
  logic [CNT_W-1:0]      cnt_q;
  logic [CNT_W-1:0]      cnt_d;
  logic                  dwell_done;
  logic                  hold_awake;
  logic                  sleep_q;

  // ------------------------------------------------------------------
  // Retirement
  // ------------------------------------------------------------------

  // An enabled pending line retires the WFI in the same cycle
  assign wfi_ready_o = wfi_valid_i & wake_i;

  // Outstanding bus traffic or a debug request keep the core running
  // but do not retire the WFI
  assign hold_awake = bus_busy_i | debug_req_i;

  // First writeback cycle is counted on the IDLE to DWELL step
  assign dwell_done = (cnt_q >= CNT_W'(`WFI_SLEEP_DELAY - 1));

  // ------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    if (!wfi_valid_i || wfi_ready_o) begin
      state_d = irq_pkg::IDLE;
      cnt_d   = '0;
    end else begin
      case (state_q)
        irq_pkg::IDLE: begin
          state_d = irq_pkg::DWELL;
          cnt_d   = CNT_W'(1);
        end
        irq_pkg::DWELL: begin
          if (dwell_done && !hold_awake) begin
            state_d = irq_pkg::ASLEEP;
          end else if (!dwell_done) begin
            cnt_d = cnt_q + CNT_W'(1);
          end
        end
        irq_pkg::ASLEEP: begin
          // Wait in DWELL again while something holds the core awake
          if (hold_awake) begin
            state_d = irq_pkg::DWELL;
          end
        end
        default: begin
          state_d = irq_pkg::IDLE;
          cnt_d   = '0;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------
  // State and output registers
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= irq_pkg::IDLE;
      cnt_q   <= '0;
      sleep_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      sleep_q <= (state_d == irq_pkg::ASLEEP);
    end
  end

  // Registered sleep request, high only in ASLEEP
  assign core_sleep_o = sleep_q;

endmodule
